// ==== rx_prot_macros.svh ====
`ifndef RX_PROT_MACROS_SVH
`define RX_PROT_MACROS_SVH

// log2 of the FIFO depth
`define RX_FIFO_AW 11

// Header register file size, one 32-bit word each
`define RX_HDR_REGS 48

// Settings address that loads the sequence number
`define RX_SEQ_ADDR 54

// Ethernet type expected in the upper half of header word 4
`define RX_ETH_TYPE 16'hBEEF

`endif

// ==== rx_prot_pkg.sv ====
`default_nettype none

package rx_prot_pkg;

   // MAC-side engine states, also the header register index
   typedef enum logic [2:0] {
      PROT_IDLE = 3'd0,
      PROT_HDR1 = 3'd1,
      PROT_HDR2 = 3'd2,
      PROT_HDR3 = 3'd3,
      PROT_HDR4 = 3'd4,
      PROT_HDR5 = 3'd5,
      PROT_PKT  = 3'd6
   } prot_state_e;

   // One FIFO word with its side bits
   typedef struct packed {
      logic        flag;
      logic        sop;
      logic        eop;
      logic        err;
      logic [31:0] data;
   } fifo_entry_t;

endpackage

`default_nettype wire

// ==== rx_set_pkg.sv ====
`default_nettype none

`include "rx_prot_macros.svh"

package rx_set_pkg;

   // Settings bus addresses
   typedef enum logic [7:0] {
      SET_HDR_W1 = 8'd1,
      SET_HDR_W2 = 8'd2,
      SET_HDR_W3 = 8'd3,
      SET_HDR_W4 = 8'd4,
      SET_SEQNUM = 8'(`RX_SEQ_ADDR)
   } set_addr_e;

endpackage

`default_nettype wire

// ==== rx_fifo_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface rx_fifo_if;

   rx_prot_pkg::fifo_entry_t wr_entry;
   logic                     write;
   logic                     full;
   rx_prot_pkg::fifo_entry_t rd_entry;
   logic                     read;
   logic                     empty;
   logic [15:0]              space;

   modport push (output wr_entry, output write, input full);
   modport pop (output read, input rd_entry, input empty);
   modport fifo (input wr_entry, input write, output full,
                 output rd_entry, input read, output empty, output space);

endinterface

`default_nettype wire

// ==== rx_header_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_prot_macros.svh"

module rx_header_regs
(
   input  wire logic                  clk,
   input  wire logic                  set_stb_i,
   input  wire rx_set_pkg::set_addr_e set_addr_i,
   input  wire logic [31:0]           set_data_i,
   input  wire logic [2:0]            hdr_addr_i,
   output logic [31:0]                hdr_data_o
);

   logic [31:0] regs [`RX_HDR_REGS];
   logic        wr_en;

   // Only addresses inside the file are written
   assign wr_en = set_stb_i && (set_addr_i < 8'(`RX_HDR_REGS));

   always_ff @(posedge clk)
   begin
      if (wr_en)
         regs[set_addr_i[5:0]] <= set_data_i;
   end

   // Read port follows the engine state
   assign hdr_data_o = regs[hdr_addr_i];

endmodule

`default_nettype wire

// ==== rx_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_fifo
#(
   parameter int AW = 11
)
(
   input  wire logic clk,
   input  wire logic rst,
   rx_fifo_if.fifo   fifo
);

   localparam int DEPTH = 1 << AW;

   rx_prot_pkg::fifo_entry_t mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          do_push;
   logic          do_pop;

   assign do_push = fifo.write && !fifo.full;
   assign do_pop  = fifo.read && !fifo.empty;

   assign fifo.full  = (count == DEPTH[AW:0]);
   assign fifo.empty = (count == '0);
   assign fifo.space = 16'(DEPTH[AW:0] - count);

   // Head word falls through
   assign fifo.rd_entry = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= fifo.wr_entry;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves the count alone
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rx_prot_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_prot_engine
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  rx_mac_ra_i,
   input  wire logic                  rx_mac_pa_i,
   input  wire logic                  rx_mac_sop_i,
   input  wire logic                  rx_mac_eop_i,
   input  wire logic                  rx_mac_err_i,
   input  wire logic [31:0]           rx_mac_data_i,
   output logic                       rx_mac_rd_o,
   input  wire logic [31:0]           hdr_data_i,
   output logic [2:0]                 hdr_addr_o,
   input  wire logic                  set_stb_i,
   input  wire rx_set_pkg::set_addr_e set_addr_i,
   input  wire logic [31:0]           set_data_i,
   rx_fifo_if.push                    push,
   output logic [7:0]                 rx_seqnum_o,
   output logic [7:0]                 rx_channel_o
);

   rx_prot_pkg::prot_state_e state;
   rx_prot_pkg::prot_state_e next_hdr;

   logic       active;
   logic       consume;
   logic       flag;
   logic       hdr_ok;
   logic [7:0] seqnum_p1;

   assign active    = (state != rx_prot_pkg::PROT_IDLE);
   assign consume   = active && rx_mac_pa_i && !push.full;
   assign seqnum_p1 = rx_seqnum_o + 8'd1;

   assign rx_mac_rd_o = active && (!push.full || !rx_mac_pa_i);
   assign hdr_addr_o  = state;

   // Every consumed word goes into the FIFO with the current flag
   assign push.write    = consume;
   assign push.wr_entry = '{flag: flag, sop: rx_mac_sop_i, eop: rx_mac_eop_i,
                            err: rx_mac_err_i, data: rx_mac_data_i};

   always_comb
   begin
      hdr_ok   = 1'b1;
      next_hdr = rx_prot_pkg::PROT_PKT;
      case (state)
         rx_prot_pkg::PROT_HDR1:
         begin
            hdr_ok   = (hdr_data_i == rx_mac_data_i);
            next_hdr = rx_prot_pkg::PROT_HDR2;
         end
         rx_prot_pkg::PROT_HDR2:
         begin
            hdr_ok   = (hdr_data_i == rx_mac_data_i);
            next_hdr = rx_prot_pkg::PROT_HDR3;
         end
         rx_prot_pkg::PROT_HDR3:
         begin
            hdr_ok   = (hdr_data_i == rx_mac_data_i);
            next_hdr = rx_prot_pkg::PROT_HDR4;
         end
         // Only the type half is checked, the channel half is ours
         rx_prot_pkg::PROT_HDR4:
         begin
            hdr_ok   = (hdr_data_i[31:16] == rx_mac_data_i[31:16]);
            next_hdr = rx_prot_pkg::PROT_HDR5;
         end
         rx_prot_pkg::PROT_HDR5:
            hdr_ok = (seqnum_p1 == rx_mac_data_i[15:8]);
         default:
            hdr_ok = 1'b1;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= rx_prot_pkg::PROT_IDLE;
         flag  <= 1'b0;
      end
      else if (!active)
      begin
         flag <= 1'b0;
         if (rx_mac_ra_i)
            state <= rx_prot_pkg::PROT_HDR1;
      end
      else if (consume)
      begin
         if (!hdr_ok)
            flag <= 1'b1;
         // A short frame may end inside the header
         if (rx_mac_eop_i || rx_mac_err_i)
            state <= rx_prot_pkg::PROT_IDLE;
         else
            state <= next_hdr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (consume && state == rx_prot_pkg::PROT_HDR4)
         rx_channel_o <= hdr_data_i[15:8];
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         rx_seqnum_o <= 8'hFF;
      else if (set_stb_i && set_addr_i == rx_set_pkg::SET_SEQNUM)
         rx_seqnum_o <= set_data_i[7:0];
      else if (consume && state == rx_prot_pkg::PROT_HDR5 && hdr_ok && !flag)
         rx_seqnum_o <= seqnum_p1;
   end

endmodule

`default_nettype wire

// ==== rx_buffer_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_buffer_writer
(
   input  wire logic  clk,
   input  wire logic  rst,
   rx_fifo_if.pop     pop,
   input  wire logic  wr_ready_i,
   input  wire logic  wr_full_i,
   output logic [31:0] wr_dat_o,
   output logic       wr_write_o,
   output logic       wr_done_o,
   output logic       wr_error_o,
   output logic       wr_flag_o
);

   logic xfer_active;
   logic last_word;

   assign last_word = pop.rd_entry.eop || pop.rd_entry.err;

   // Stop at the end of a packet or when the buffer fills
   always_ff @(posedge clk)
   begin
      if (rst)
         xfer_active <= 1'b0;
      else if (wr_full_i || (wr_write_o && last_word))
         xfer_active <= 1'b0;
      else if (wr_ready_i && !pop.empty)
         xfer_active <= 1'b1;
   end

   assign wr_write_o = xfer_active && !pop.empty;
   assign pop.read   = wr_write_o;
   assign wr_dat_o   = pop.rd_entry.data;
   assign wr_done_o  = pop.rd_entry.eop && wr_write_o;
   assign wr_error_o = pop.rd_entry.err && wr_write_o;
   assign wr_flag_o  = pop.rd_entry.flag && !pop.empty;

endmodule

`default_nettype wire

// ==== rx_prot_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_prot_macros.svh"

module rx_prot_top
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        rx_mac_ra_i,
   output logic             rx_mac_rd_o,
   input  wire logic [31:0] rx_mac_data_i,
   input  wire logic        rx_mac_pa_i,
   input  wire logic        rx_mac_sop_i,
   input  wire logic        rx_mac_eop_i,
   input  wire logic        rx_mac_err_i,
   output logic [31:0]      wr_dat_o,
   output logic             wr_write_o,
   output logic             wr_done_o,
   output logic             wr_error_o,
   input  wire logic        wr_ready_i,
   input  wire logic        wr_full_i,
   output logic             wr_flag_o,
   input  wire logic        set_stb_i,
   input  wire logic [7:0]  set_addr_i,
   input  wire logic [31:0] set_data_i,
   output logic [15:0]      rx_fifo_status_o,
   output logic [7:0]       rx_seqnum_o,
   output logic [7:0]       rx_channel_o
);

   logic [2:0]  hdr_addr;
   logic [31:0] hdr_data;

   rx_fifo_if fifo_bus ();

   assign rx_fifo_status_o = fifo_bus.space;

   rx_header_regs i_header_regs (
      .clk        (clk),
      .set_stb_i  (set_stb_i),
      .set_addr_i (rx_set_pkg::set_addr_e'(set_addr_i)),
      .set_data_i (set_data_i),
      .hdr_addr_i (hdr_addr),
      .hdr_data_o (hdr_data)
   );

   rx_fifo #(.AW(`RX_FIFO_AW)) i_fifo (
      .clk  (clk),
      .rst  (rst),
      .fifo (fifo_bus.fifo)
   );

   rx_prot_engine i_engine (
      .clk           (clk),
      .rst           (rst),
      .rx_mac_ra_i   (rx_mac_ra_i),
      .rx_mac_pa_i   (rx_mac_pa_i),
      .rx_mac_sop_i  (rx_mac_sop_i),
      .rx_mac_eop_i  (rx_mac_eop_i),
      .rx_mac_err_i  (rx_mac_err_i),
      .rx_mac_data_i (rx_mac_data_i),
      .rx_mac_rd_o   (rx_mac_rd_o),
      .hdr_data_i    (hdr_data),
      .hdr_addr_o    (hdr_addr),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (rx_set_pkg::set_addr_e'(set_addr_i)),
      .set_data_i    (set_data_i),
      .push          (fifo_bus.push),
      .rx_seqnum_o   (rx_seqnum_o),
      .rx_channel_o  (rx_channel_o)
   );

   rx_buffer_writer i_writer (
      .clk        (clk),
      .rst        (rst),
      .pop        (fifo_bus.pop),
      .wr_ready_i (wr_ready_i),
      .wr_full_i  (wr_full_i),
      .wr_dat_o   (wr_dat_o),
      .wr_write_o (wr_write_o),
      .wr_done_o  (wr_done_o),
      .wr_error_o (wr_error_o),
      .wr_flag_o  (wr_flag_o)
   );

endmodule

`default_nettype wire

// ==== rx_prot_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_prot_macros.svh"

module rx_prot_sva
(
   input wire logic                     clk,
   input wire logic                     rst,
   input wire rx_prot_pkg::prot_state_e state_i,
   input wire logic                     mac_rd_i,
   input wire logic                     write_i,
   input wire logic                     done_i,
   input wire logic                     error_i,
   input wire logic [15:0]              space_i
);

   localparam logic [15:0] FIFO_DEPTH = 16'(1 << `RX_FIFO_AW);

   // Full free space means the FIFO is empty
   a_no_write_empty: assert property (@(posedge clk) disable iff (rst)
      write_i |-> (space_i != FIFO_DEPTH))
      else $error("buffer write while the FIFO is empty");

   a_no_read_idle: assert property (@(posedge clk) disable iff (rst)
      (state_i == rx_prot_pkg::PROT_IDLE) |-> !mac_rd_i)
      else $error("MAC read raised while the engine is idle");

   a_done_with_write: assert property (@(posedge clk) disable iff (rst)
      done_i |-> write_i)
      else $error("done strobe without a buffer write");

   a_error_with_write: assert property (@(posedge clk) disable iff (rst)
      error_i |-> write_i)
      else $error("error strobe without a buffer write");

endmodule

bind rx_prot_top rx_prot_sva i_sva (
   .clk      (clk),
   .rst      (rst),
   .state_i  (i_engine.state),
   .mac_rd_i (rx_mac_rd_o),
   .write_i  (wr_write_o),
   .done_i   (wr_done_o),
   .error_i  (wr_error_o),
   .space_i  (rx_fifo_status_o)
);

`default_nettype wire

// ==== rx_prot_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_prot_macros.svh"

module rx_prot_tb;

   localparam int          CLK_NS     = 10;
   localparam logic [15:0] FIFO_DEPTH = 16'(1 << `RX_FIFO_AW);
   localparam int          BP_PKTS    = 4;
   localparam int          BP_LEN     = 600;
   // Tests 1 to 3 and 6 send 12 words each, test 4 sends two packets of 10
   localparam int          TOTAL_WORDS = 12 * 4 + 20 + BP_PKTS * BP_LEN;

   logic        clk;
   logic        rst;
   logic        rx_mac_ra_i;
   logic        rx_mac_rd_o;
   logic [31:0] rx_mac_data_i;
   logic        rx_mac_pa_i;
   logic        rx_mac_sop_i;
   logic        rx_mac_eop_i;
   logic        rx_mac_err_i;
   logic [31:0] wr_dat_o;
   logic        wr_write_o;
   logic        wr_done_o;
   logic        wr_error_o;
   logic        wr_ready_i;
   logic        wr_full_i;
   logic        wr_flag_o;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic [15:0] rx_fifo_status_o;
   logic [7:0]  rx_seqnum_o;
   logic [7:0]  rx_channel_o;

   // Reference model state
   logic [31:0] hdr_model [8];
   logic [7:0]  seq_model;
   logic [35:0] exp_q [$];
   logic [31:0] rand_state;
   logic [31:0] ready_state;
   logic        send_done;
   int          errors;
   int          failed_tests;
   int          out_words;
   int          out_flags;
   int          out_done;
   int          out_errs;

   rx_prot_top i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial
   begin
      #(20 * TOTAL_WORDS * CLK_NS);
      $display("watchdog expired before all tests finished");
      $display("sim failed");
      $finish;
   end

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic report_err(input string msg);
      $display("ERR %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      if (addr >= 8'd1 && addr <= 8'd4)
         hdr_model[addr[2:0]] = data;
      if (addr == 8'(`RX_SEQ_ADDR))
         seq_model = data[7:0];
      @(posedge clk);
      #1;
      set_stb_i = 1'b0;
   endtask

   task automatic send_packet(input int len, input bit bad_hdr, input bit bad_seq,
                              input bit end_err, input bit gaps);
      logic [31:0] words [$];
      logic        sticky;
      logic        miss;
      int          idx;
      sticky = 1'b0;
      idx    = 0;
      words.push_back(hdr_model[1]);
      words.push_back(bad_hdr ? (hdr_model[2] ^ 32'h0000_0100) : hdr_model[2]);
      words.push_back(hdr_model[3]);
      rand_state = lcg(rand_state);
      words.push_back({hdr_model[4][31:16], rand_state[15:0]});
      words.push_back({rand_state[31:16], seq_model + (bad_seq ? 8'd5 : 8'd1), 8'h00});
      while (words.size() < len)
      begin
         rand_state = lcg(rand_state);
         words.push_back(rand_state);
      end
      // With no word offered, the MAC read shows the engine is out of idle
      @(posedge clk);
      #1;
      rx_mac_ra_i = 1'b1;
      do
         @(negedge clk);
      while (!rx_mac_rd_o);
      @(posedge clk);
      #1;
      rx_mac_ra_i = 1'b0;
      while (idx < len)
      begin
         rand_state    = lcg(rand_state);
         rx_mac_pa_i   = !gaps || (rand_state[9:8] != 2'b00);
         rx_mac_data_i = words[idx];
         rx_mac_sop_i  = (idx == 0);
         rx_mac_eop_i  = (idx == len - 1) && !end_err;
         rx_mac_err_i  = (idx == len - 1) && end_err;
         @(negedge clk);
         if (rx_mac_pa_i && rx_mac_rd_o)
         begin
            exp_q.push_back({sticky, rx_mac_sop_i, rx_mac_eop_i, rx_mac_err_i, words[idx]});
            case (idx)
               0, 1, 2:
                  miss = (words[idx] != hdr_model[3'(idx + 1)]);
               3:
                  miss = (words[idx][31:16] != hdr_model[4][31:16]);
               4:
               begin
                  miss = (words[idx][15:8] != seq_model + 8'd1);
                  if (!miss && !sticky)
                     seq_model = seq_model + 8'd1;
               end
               default:
                  miss = 1'b0;
            endcase
            sticky = sticky || miss;
            idx++;
         end
         @(posedge clk);
         #1;
      end
      rx_mac_pa_i  = 1'b0;
      rx_mac_sop_i = 1'b0;
      rx_mac_eop_i = 1'b0;
      rx_mac_err_i = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0)
         @(negedge clk);
      // Last pop lands on the next edge
      @(negedge clk);
   endtask

   task automatic end_test(input int num, input string name, input int errs_before);
      $display("test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "FAILED");
      if (errors != errs_before)
         failed_tests++;
   endtask

   // Output side, sampled between edges
   always @(negedge clk)
   begin
      logic [35:0] head;
      if (!rst && ((!wr_write_o && (wr_done_o || wr_error_o)) ||
                   (wr_write_o && rx_fifo_status_o == FIFO_DEPTH)))
      begin
         $display("buffer strobes broke their rules at %0t", $time);
         $display("sim failed");
         $finish;
      end
      else if (!rst && wr_write_o)
      begin
         out_words++;
         out_flags += int'(wr_flag_o);
         out_done  += int'(wr_done_o);
         out_errs  += int'(wr_error_o);
         if (exp_q.size() == 0)
            report_err("buffer write with no word expected");
         else
         begin
            head = exp_q.pop_front();
            assert (wr_dat_o == head[31:0] && wr_flag_o == head[35])
               else report_err($sformatf("word %h flag %b, expected %h flag %b",
                                         wr_dat_o, wr_flag_o, head[31:0], head[35]));
            assert (wr_done_o == head[33] && wr_error_o == head[32])
               else report_err($sformatf("done %b error %b, expected %b %b",
                                         wr_done_o, wr_error_o, head[33], head[32]));
         end
      end
   end

   initial
   begin
      int         e0;
      int         f0;
      int         d0;
      int         x0;
      int         w0;
      logic [7:0] seq0;
      rst           = 1'b1;
      rx_mac_ra_i   = 1'b0;
      rx_mac_data_i = '0;
      rx_mac_pa_i   = 1'b0;
      rx_mac_sop_i  = 1'b0;
      rx_mac_eop_i  = 1'b0;
      rx_mac_err_i  = 1'b0;
      wr_ready_i    = 1'b1;
      wr_full_i     = 1'b0;
      set_stb_i     = 1'b0;
      set_addr_i    = '0;
      set_data_i    = '0;
      seq_model     = 8'hFF;
      rand_state    = 32'h21979e75;
      ready_state   = lcg(32'h21979e75);
      send_done     = 1'b0;
      errors        = 0;
      failed_tests  = 0;
      out_words     = 0;
      out_flags     = 0;
      out_done      = 0;
      out_errs      = 0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      e0 = errors;
      write_setting(8'd1, 32'h1234_5678);
      write_setting(8'd2, 32'hCAFE_0002);
      write_setting(8'd3, 32'h0A0B_0C0D);
      write_setting(8'd4, {`RX_ETH_TYPE, 8'h2A, 8'h00});
      seq0 = seq_model;
      f0   = out_flags;
      d0   = out_done;
      send_packet(12, 1'b0, 1'b0, 1'b0, 1'b0);
      wait_drain();
      assert (out_flags == f0) else report_err("flagged word in a good packet");
      assert (out_done == d0 + 1) else report_err("done strobe count not one");
      assert (rx_seqnum_o == seq0 + 8'd1) else report_err("sequence number did not advance");
      assert (rx_channel_o == 8'h2A) else report_err("channel not taken from header word 4");
      end_test(1, "good packet", e0);

      e0   = errors;
      seq0 = seq_model;
      f0   = out_flags;
      send_packet(12, 1'b1, 1'b0, 1'b0, 1'b0);
      wait_drain();
      assert (out_flags == f0 + 10) else report_err("words after bad header not flagged");
      assert (rx_seqnum_o == seq0) else report_err("sequence number moved on bad header");
      end_test(2, "header mismatch", e0);

      e0   = errors;
      seq0 = seq_model;
      f0   = out_flags;
      send_packet(12, 1'b0, 1'b1, 1'b0, 1'b0);
      wait_drain();
      assert (out_flags == f0 + 7) else report_err("words after bad sequence not flagged");
      assert (rx_seqnum_o == seq0) else report_err("sequence number moved on bad sequence");
      end_test(3, "bad sequence number", e0);

      e0   = errors;
      seq0 = seq_model;
      f0   = out_flags;
      d0   = out_done;
      x0   = out_errs;
      send_packet(10, 1'b0, 1'b0, 1'b1, 1'b0);
      send_packet(10, 1'b0, 1'b0, 1'b0, 1'b0);
      wait_drain();
      assert (out_errs == x0 + 1 && out_done == d0 + 1)
         else report_err("done and error strobe counts wrong");
      assert (out_flags == f0) else report_err("flagged word after error packet");
      assert (rx_seqnum_o == seq0 + 8'd2) else report_err("sequence number not advanced twice");
      end_test(4, "error-terminated packet", e0);

      e0 = errors;
      w0 = out_words;
      @(posedge clk);
      #1;
      wr_full_i = 1'b1;
      send_done = 1'b0;
      fork
         begin
            repeat (BP_PKTS) send_packet(BP_LEN, 1'b0, 1'b0, 1'b0, 1'b1);
            send_done = 1'b1;
         end
         begin
            while (rx_fifo_status_o != 16'd0)
               @(negedge clk);
            @(posedge clk);
            #1;
            wr_full_i = 1'b0;
            while (!send_done || exp_q.size() != 0)
            begin
               ready_state = lcg(ready_state);
               wr_ready_i  = ready_state[12];
               @(posedge clk);
               #1;
            end
            wr_ready_i = 1'b1;
         end
      join
      wait_drain();
      assert (out_words == w0 + BP_PKTS * BP_LEN) else report_err("output word count wrong");
      assert (rx_fifo_status_o == FIFO_DEPTH) else report_err("FIFO space not back to depth");
      end_test(5, "back-pressure and gaps", e0);

      e0 = errors;
      f0 = out_flags;
      write_setting(8'(`RX_SEQ_ADDR), 32'h0000_0040);
      assert (rx_seqnum_o == 8'h40) else report_err("sequence register load ignored");
      send_packet(12, 1'b0, 1'b0, 1'b0, 1'b0);
      wait_drain();
      assert (out_flags == f0) else report_err("flagged word after sequence load");
      assert (rx_seqnum_o == 8'h41) else report_err("sequence number not one past loaded value");
      end_test(6, "sequence register load", e0);

      $display("tests 6, failed %0d, errors %0d", failed_tests, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
rx_prot_pkg.sv
rx_set_pkg.sv
rx_fifo_if.sv
rx_header_regs.sv
rx_fifo.sv
rx_prot_engine.sv
rx_buffer_writer.sv
rx_prot_top.sv
rx_prot_sva.sv
rx_prot_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := rx_prot_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
